/* verilog.f */
+incdir+source
source/capture_pkg.sv
source/sample_bus_if.sv
source/arm_trigger_decode.sv
source/segment_sequencer.sv
source/word_packer.sv
source/adc_capture_top.sv
sim/clock_gen.sv
sim/tb_adc_capture.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_adc_capture
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_adc_capture.sv */
`timescale 1ns/1ns
`include "capture_cfg.svh"

module tb_adc_capture;
    import capture_pkg::*;

    // worst case is about 1700 cycles for the whole test list
    localparam int MAX_CYCLES = 4000;

    logic adc_sampleclk;
    logic reset;
    sample_t adc_data_i = 12'd1;
    logic arm_i;
    logic capture_go_i;
    logic [`SEGMENT_W-1:0] num_segments_i;
    logic [`COUNT_W-1:0] max_samples_i;
    logic [`DOWNSAMPLE_W-1:0] downsample_i;
    word_t word_o;
    logic word_valid_o;
    logic armed_o;
    logic capture_done_o;
    logic capture_stop_o;
    capture_state_t state_o;
    logic clip_error_o;
    logic segment_error_o;

    sample_t tick = '0;        // free-running data counter
    sample_t data_base = 12'd1;
    word_t words[$];           // captured words of the current test
    string cur_test;
    int errors = 0;
    int errors_at_start;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;

    clock_gen u_clk (.clk_o(adc_sampleclk), .reset_o(reset));

    adc_capture_top DUT (.*);

    always @(negedge adc_sampleclk) begin
        tick       <= tick + 1'b1;
        adc_data_i <= data_base + tick;
        if (word_valid_o)
            words.push_back(word_o);   // strobe is stable mid-cycle
    end

    always @(posedge adc_sampleclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles in test %s", cycles, cur_test);
            $display(">>> FAIL");
            $finish;
        end
    end

    assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(capture_done_o) |-> capture_stop_o)
    else begin
        $display("capture_done_o rose without capture_stop_o in test %s", cur_test);
        errors++;
    end

    assert property (@(posedge adc_sampleclk) disable iff (reset)
        capture_stop_o |=> !armed_o)
    else begin
        $display("armed_o stayed high after capture_stop_o in test %s", cur_test);
        errors++;
    end

    assert property (@(posedge adc_sampleclk) disable iff (reset)
        word_valid_o |-> state_o != st_idle)
    else begin
        $display("word strobe outside a capture in test %s", cur_test);
        errors++;
    end

    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        assert (actual == expected)
        else begin
            $display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(string name);
        cur_test        = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %s passed", cur_test);
        end else begin
            $display("test %s failed with %0d errors", cur_test, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    // next sample on adc_data_i will be first
    task automatic start_data(sample_t first);
        @(posedge adc_sampleclk);
        data_base = first - tick;
    endtask

    task automatic arm_capture();
        @(negedge adc_sampleclk);
        arm_i = 1'b1;
        @(negedge adc_sampleclk);
        arm_i = 1'b0;
        @(negedge adc_sampleclk);
        check_value("armed_o after arm", 64'd1, 64'(armed_o));
    endtask

    task automatic pulse_trigger();
        @(negedge adc_sampleclk);
        capture_go_i = 1'b1;
        @(negedge adc_sampleclk);
        capture_go_i = 1'b0;
        repeat (2) @(negedge adc_sampleclk);   // trigger is taken 3 cycles after the edge
    endtask

    // samples from the word stream, first word on top of each 3-word group
    function automatic sample_t get_sample(int idx);
        logic [`GROUP_WORDS*`WORD_W-1:0] grp;
        int g;
        int k;
        g   = idx / `GROUP_SAMPLES;
        k   = idx % `GROUP_SAMPLES;
        grp = {words[3*g], words[3*g+1], words[3*g+2]};
        return sample_t'(grp >> (`SAMPLE_W * (`GROUP_SAMPLES - 1 - k)));
    endfunction

    task automatic run_capture(string name, int segs, int samples, int ds, sample_t first,
                               bit retrig, bit clip_exp);
        int total;
        int n_words;
        sample_t diff;
        start_test(name);
        @(negedge adc_sampleclk);
        num_segments_i = 16'(segs);
        max_samples_i  = 32'(samples);
        downsample_i   = 13'(ds);
        start_data(first);
        words.delete();
        arm_capture();
        for (int s = 0; s < segs; s++) begin
            while (s > 0 && state_o != st_segment_done)
                @(negedge adc_sampleclk);
            pulse_trigger();
            if (retrig && s == 0) begin
                repeat (8) @(negedge adc_sampleclk);
                pulse_trigger();   // lands inside the running segment
            end
            while (state_o == st_triggered)
                @(negedge adc_sampleclk);
        end
        while (!capture_done_o)
            @(negedge adc_sampleclk);
        check_value("capture_stop_o", 64'd1, 64'(capture_stop_o));
        check_value("clip_error_o", 64'(clip_exp), 64'(clip_error_o));
        check_value("segment_error_o", 64'(retrig), 64'(segment_error_o));
        while (state_o != st_idle)
            @(negedge adc_sampleclk);
        check_value("armed_o after stop", 64'd0, 64'(armed_o));
        total   = segs * samples;
        n_words = `GROUP_WORDS * ((total + `GROUP_SAMPLES - 1) / `GROUP_SAMPLES);
        check_value("word count", 64'(n_words), 64'(words.size()));
        if (words.size() == n_words) begin
            for (int i = 0; i < n_words / `GROUP_WORDS * `GROUP_SAMPLES; i++) begin
                diff = get_sample(i) - get_sample(i - 1);
                if (i >= total)
                    check_value($sformatf("filler sample %0d", i), 64'd0, 64'(get_sample(i)));
                else if (i % samples != 0)
                    check_value($sformatf("sample step %0d", i), 64'(ds + 1), 64'(diff));
            end
        end
        end_test();
    endtask

    initial begin
        int segs;
        int samples;
        int ds;
        arm_i          = 1'b0;
        capture_go_i   = 1'b0;
        num_segments_i = 16'd1;
        max_samples_i  = 32'd16;
        downsample_i   = '0;
        void'($urandom(32'hc726));

        start_test("reset");
        do @(posedge adc_sampleclk); while (reset);
        @(negedge adc_sampleclk);
        check_value("word_valid_o", 64'd0, 64'(word_valid_o));
        check_value("armed_o", 64'd0, 64'(armed_o));
        check_value("capture_done_o", 64'd0, 64'(capture_done_o));
        check_value("capture_stop_o", 64'd0, 64'(capture_stop_o));
        check_value("clip_error_o", 64'd0, 64'(clip_error_o));
        check_value("segment_error_o", 64'd0, 64'(segment_error_o));
        check_value("state_o", 64'(st_idle), 64'(state_o));
        end_test();

        for (int t = 0; t < 4; t++) begin
            segs    = 1 + $urandom % 3;
            samples = 1 + $urandom % 24;
            ds      = $urandom % 4;
            run_capture($sformatf("random_%0d", t), segs, samples, ds, 12'd1, 1'b0, 1'b0);
        end

        run_capture("segment_error", 2, 20, 3, 12'd1, 1'b1, 1'b0);
        run_capture("clip", 1, 32, 0, 12'd4080, 1'b0, 1'b1);   // runs through 4095 and 0

        start_test("rearm");
        arm_capture();
        check_value("clip_error_o", 64'd0, 64'(clip_error_o));
        check_value("segment_error_o", 64'd0, 64'(segment_error_o));
        check_value("capture_done_o", 64'd0, 64'(capture_done_o));
        end_test();

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sim/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen (
    output logic clk_o,
    output logic reset_o
);

    localparam int HALF_PERIOD  = 20;   // 40 ns period
    localparam int RESET_CYCLES = 2;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;   // released on a falling edge
    end

endmodule

/* source/adc_capture_top.sv */
`timescale 1ns/1ns
`include "capture_cfg.svh"

module adc_capture_top (
    input  logic                        adc_sampleclk,
    input  logic                        reset,
    input  capture_pkg::sample_t        adc_data_i,
    input  logic                        arm_i,
    input  logic                        capture_go_i,
    input  logic [`SEGMENT_W-1:0]       num_segments_i,
    input  logic [`COUNT_W-1:0]         max_samples_i,
    input  logic [`DOWNSAMPLE_W-1:0]    downsample_i,
    output capture_pkg::word_t          word_o,
    output logic                        word_valid_o,
    output logic                        armed_o,
    output logic                        capture_done_o,
    output logic                        capture_stop_o,
    output capture_pkg::capture_state_t state_o,
    output logic                        clip_error_o,
    output logic                        segment_error_o
);

    logic arm_pulse;
    logic trig_pulse;
    logic trig_level;

    sample_bus_if bus ();

    arm_trigger_decode u_decode (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .arm_i          (arm_i),
        .capture_go_i   (capture_go_i),
        .capture_stop_i (capture_stop_o),   // stop disarms
        .arm_pulse_o    (arm_pulse),
        .trig_pulse_o   (trig_pulse),
        .trig_level_o   (trig_level),
        .armed_o        (armed_o)
    );

    segment_sequencer u_execute (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_data_i      (adc_data_i),
        .arm_pulse_i     (arm_pulse),
        .trig_pulse_i    (trig_pulse),
        .trig_level_i    (trig_level),
        .armed_i         (armed_o),
        .num_segments_i  (num_segments_i),
        .max_samples_i   (max_samples_i),
        .downsample_i    (downsample_i),
        .bus             (bus.source),
        .capture_stop_o  (capture_stop_o),
        .capture_done_o  (capture_done_o),
        .clip_error_o    (clip_error_o),
        .segment_error_o (segment_error_o),
        .state_o         (state_o)
    );

    word_packer u_result (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .bus           (bus.sink),
        .word_o        (word_o),
        .word_valid_o  (word_valid_o)
    );

endmodule

/* source/word_packer.sv */
`timescale 1ns/1ns
`include "capture_cfg.svh"

module word_packer (
    input  logic               adc_sampleclk,
    input  logic               reset,
    sample_bus_if.sink         bus,
    output capture_pkg::word_t word_o,
    output logic               word_valid_o
);
    import capture_pkg::*;

    // word 0 takes 6 samples (5x12 + 4), words 1 and 2 take 5 each
    localparam int SHIFT_W = 6 * `SAMPLE_W;

    logic [SHIFT_W-1:0] shifter;
    logic [2:0]         sample_cnt;    // samples into the current word
    logic [1:0]         phase;         // word index within the group
    logic [1:0]         close_phase;   // phase of the word just closed
    logic               wide_valid;
    logic               close_word;
    sample_t            sample_in;

    assign sample_in  = bus.filler ? '0 : bus.sample;
    assign close_word = bus.sample_valid &&
                        (sample_cnt == ((phase == 2'd0) ? 3'd5 : 3'd4));

    always_ff @(posedge adc_sampleclk) begin
        if (bus.sample_valid)
            shifter <= {shifter[SHIFT_W-`SAMPLE_W-1:0], sample_in};   // oldest at top
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || bus.restart) begin
            sample_cnt   <= '0;
            phase        <= '0;
            close_phase  <= '0;
            wide_valid   <= 1'b0;
            word_valid_o <= 1'b0;
        end else begin
            wide_valid   <= close_word;
            word_valid_o <= wide_valid;
            if (close_word) begin
                sample_cnt  <= '0;
                close_phase <= phase;
                if (phase == 2'(`GROUP_WORDS - 1))
                    phase <= '0;
                else
                    phase <= phase + 1'b1;
            end else if (bus.sample_valid) begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

    // pick the 64-bit window, the leftover bits stay for the next word
    always_ff @(posedge adc_sampleclk) begin
        if (wide_valid) begin
            case (close_phase)
                2'd0:    word_o <= shifter[SHIFT_W-1 -: `WORD_W];   // 8 bits left over
                2'd1:    word_o <= shifter[SHIFT_W-5 -: `WORD_W];   // 4 bits left over
                default: word_o <= shifter[`WORD_W-1:0];
            endcase
        end
    end

    // at least five samples go into each word
    assert property (@(posedge adc_sampleclk) disable iff (reset)
        word_valid_o |=> !word_valid_o);

endmodule

/* source/segment_sequencer.sv */
`timescale 1ns/1ns
`include "capture_cfg.svh"

module segment_sequencer (
    input  logic                     adc_sampleclk,
    input  logic                     reset,
    input  capture_pkg::sample_t     adc_data_i,
    input  logic                     arm_pulse_i,
    input  logic                     trig_pulse_i,
    input  logic                     trig_level_i,
    input  logic                     armed_i,
    input  logic [`SEGMENT_W-1:0]    num_segments_i,
    input  logic [`COUNT_W-1:0]      max_samples_i,
    input  logic [`DOWNSAMPLE_W-1:0] downsample_i,
    sample_bus_if.source             bus,
    output logic                     capture_stop_o,
    output logic                     capture_done_o,
    output logic                     clip_error_o,
    output logic                     segment_error_o,
    output capture_pkg::capture_state_t state_o
);
    import capture_pkg::*;

    localparam int GROUP_W = $clog2(`GROUP_SAMPLES);

    capture_state_t           state_q;
    logic [`DOWNSAMPLE_W-1:0] ds_cnt;
    logic [`COUNT_W-1:0]      sample_cnt;
    logic [`COUNT_W-1:0]      sample_cnt_next;
    logic [`SEGMENT_W-1:0]    seg_cnt;     // completed segments
    logic [GROUP_W-1:0]       group_cnt;   // wraps at a full packing group
    logic [1:0]               done_cnt;
    logic                     segs_done;
    logic                     take_first;
    logic                     take;
    logic                     last_take;
    logic                     fill;

    assign segs_done = (seg_cnt >= num_segments_i);

    // a segment opens with the sample on the trigger pulse cycle
    assign take_first = trig_pulse_i &&
                        ((state_q == st_idle && armed_i) ||
                         (state_q == st_segment_done && !segs_done));
    assign take = !arm_pulse_i &&
                  (take_first || (state_q == st_triggered && ds_cnt == downsample_i));
    assign sample_cnt_next = sample_cnt + 1'b1;
    assign last_take = take && (sample_cnt_next >= max_samples_i);

    // pad the final packing group with zero samples
    assign fill = !arm_pulse_i && state_q == st_segment_done && segs_done &&
                  group_cnt != '0;

    assign bus.restart = arm_pulse_i;
    assign state_o     = state_q;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_pulse_i) begin   // arming aborts and starts over
            state_q          <= st_idle;
            ds_cnt           <= '0;
            sample_cnt       <= '0;
            seg_cnt          <= '0;
            group_cnt        <= '0;
            done_cnt         <= '0;
            capture_stop_o   <= 1'b0;
            capture_done_o   <= 1'b0;
            clip_error_o     <= 1'b0;
            segment_error_o  <= 1'b0;
            bus.sample_valid <= 1'b0;
            bus.filler       <= 1'b0;
        end else begin
            bus.sample_valid <= take || fill;
            bus.filler       <= fill;

            if (take_first || ds_cnt == downsample_i)
                ds_cnt <= '0;
            else
                ds_cnt <= ds_cnt + 1'b1;

            if (last_take)
                sample_cnt <= '0;
            else if (take)
                sample_cnt <= sample_cnt_next;

            if (take || fill)
                group_cnt <= group_cnt + 1'b1;

            if (take && (adc_data_i == '1 || adc_data_i == '0))
                clip_error_o <= 1'b1;   // sample at either rail
            if (state_q == st_triggered && trig_pulse_i)
                segment_error_o <= 1'b1;   // trigger came before the segment ended

            case (state_q)
                st_idle, st_triggered: begin
                    if (last_take) begin
                        seg_cnt <= seg_cnt + 1'b1;
                        state_q <= st_segment_done;
                    end else if (take_first) begin
                        state_q <= st_triggered;
                    end
                end
                st_segment_done: begin
                    if (last_take) begin
                        seg_cnt <= seg_cnt + 1'b1;   // one-sample segment
                    end else if (take_first) begin
                        state_q <= st_triggered;
                    end else if (segs_done && group_cnt == '0) begin
                        capture_stop_o <= 1'b1;
                        capture_done_o <= 1'b1;
                        done_cnt       <= '0;
                        state_q        <= st_done;
                    end
                end
                st_done: begin
                    if (done_cnt == 2'd3) begin
                        capture_stop_o <= 1'b0;
                        state_q        <= st_idle;
                    end else begin
                        done_cnt <= done_cnt + 1'b1;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (take)
            bus.sample <= adc_data_i;
    end

    assert property (@(posedge adc_sampleclk) disable iff (reset)
        bus.sample_valid |-> state_q != st_idle);

    assert property (@(posedge adc_sampleclk) disable iff (reset)
        bus.filler |-> segs_done);

endmodule

/* source/arm_trigger_decode.sv */
`timescale 1ns/1ns

module arm_trigger_decode (
    input  logic adc_sampleclk,
    input  logic reset,
    input  logic arm_i,
    input  logic capture_go_i,
    input  logic capture_stop_i,
    output logic arm_pulse_o,
    output logic trig_pulse_o,
    output logic trig_level_o,
    output logic armed_o
);

    logic arm_r;
    logic go_r2;   // second trigger stage, trig_level_o is the first

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r        <= 1'b0;
            arm_pulse_o  <= 1'b0;
            trig_level_o <= 1'b0;
            go_r2        <= 1'b0;
            trig_pulse_o <= 1'b0;
            armed_o      <= 1'b0;
        end else begin
            arm_r        <= arm_i;
            arm_pulse_o  <= arm_i & ~arm_r;          // rising edge of arm
            trig_level_o <= capture_go_i;
            go_r2        <= trig_level_o;
            trig_pulse_o <= trig_level_o & ~go_r2;   // rising edge, two cycles late

            // a new arm wins over a stop seen in the same cycle
            if (arm_pulse_o)
                armed_o <= 1'b1;
            else if (capture_stop_i)
                armed_o <= 1'b0;
        end
    end

    // both pulses are single-cycle edge strobes
    assert property (@(posedge adc_sampleclk) disable iff (reset)
        arm_pulse_o |=> !arm_pulse_o);

    assert property (@(posedge adc_sampleclk) disable iff (reset)
        trig_pulse_o |=> !trig_pulse_o);

endmodule

/* source/sample_bus_if.sv */
`timescale 1ns/1ns

// sample stream from the sequencer to the packer, no back-pressure
interface sample_bus_if;
    import capture_pkg::*;

    logic    sample_valid;   // one-cycle strobe per sample
    sample_t sample;
    logic    filler;         // padding sample, packed as zero
    logic    restart;        // arm pulse, clears the packer

    modport source (
        output sample_valid, sample, filler, restart
    );

    modport sink (
        input sample_valid, sample, filler, restart
    );

endinterface

/* source/capture_pkg.sv */
`include "capture_cfg.svh"

package capture_pkg;

    // encoding follows the capture status register of the full front end,
    // the presample states are not present here
    typedef enum logic [2:0] {
        st_idle         = 3'd0,
        st_triggered    = 3'd3,
        st_segment_done = 3'd4,
        st_done         = 3'd5
    } capture_state_t;

    typedef logic [`SAMPLE_W-1:0] sample_t;   // raw adc sample
    typedef logic [`WORD_W-1:0]   word_t;     // packed output word

endpackage

/* source/capture_cfg.svh */
`ifndef CAPTURE_CFG_SVH
`define CAPTURE_CFG_SVH

// adc sample and packed output word
`define SAMPLE_W      12
`define WORD_W        64

// 16 samples of 12 bits fill exactly 3 words of 64 bits
`define GROUP_SAMPLES 16
`define GROUP_WORDS   3

// register field widths
`define DOWNSAMPLE_W  13   // samples skipped between captured ones
`define SEGMENT_W     16
`define COUNT_W       32   // samples per segment

`endif
